// File: common/st_link_cfg.svh
//////////////////////////////////////////////////////////////////////
// Stream link sizing macros
// FIFO depth, credit counter width and debug status width
//////////////////////////////////////////////////////////////////////

`ifndef ST_LINK_CFG_SVH
`define ST_LINK_CFG_SVH

// Receive FIFO entries, also the credit the sender starts with
`define ST_LINK_FIFO_DEPTH 8

// Credit count and FIFO level, must hold 0 up to the depth
`define ST_LINK_CREDIT_W 4

// Debug status word
`define ST_LINK_STATUS_W 16

`endif

// File: common/st_link_pkg.sv
//////////////////////////////////////////////////////////////////////
// Stream link types
// Beat fields, packed link word and consumer FSM states
//////////////////////////////////////////////////////////////////////

package st_link_pkg;

  // AXI-Stream beat fields
  typedef logic [31:0] st_data_t;
  typedef logic [3:0]  st_keep_t;

  // Link word is user bit on top, then keep, then data
  localparam int LINK_WORD_W = 1 + $bits(st_keep_t) + $bits(st_data_t);

  typedef logic [LINK_WORD_W-1:0] link_word_t;

  // Consumer output register state
  // EMPTY means nothing held, HOLD means a beat is on the output
  typedef enum logic {
    EMPTY,
    HOLD
  } user_state_t;

endpackage

// File: common/st_link_if.sv
//////////////////////////////////////////////////////////////////////
// Logic link interface
// Push and word forward, credit back, sender online flag
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

interface st_link_if;
  import st_link_pkg::*;

  // Forward path, one word per push
  logic       push;
  link_word_t word;

  // One pulse per freed receive entry
  logic       credit;

  // Sender online, lets the receiver clear its debug counters
  logic       online;

  modport sender (
    output push,
    output word,
    output online,
    input  credit
  );

  modport receiver (
    input  push,
    input  word,
    input  online,
    output credit
  );

endinterface

// File: st_link_tx/st_link_tx.sv
//////////////////////////////////////////////////////////////////////
// Transmit packer
// Accepts AXI-Stream beats and pushes link words against credit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "st_link_cfg.svh"

module st_link_tx (
  input  logic                  clk_wr,
  input  logic                  reset,
  input  logic                  tx_online,
  input  st_link_pkg::st_data_t in_tdata,
  input  st_link_pkg::st_keep_t in_tkeep,
  input  logic                  in_tuser,
  input  logic                  in_tvalid,
  output logic                  in_tready,
  st_link_if.sender             link
);

  localparam int DEPTH = `ST_LINK_FIFO_DEPTH;
  localparam int CW    = `ST_LINK_CREDIT_W;

  logic [CW-1:0] credit_cnt;
  logic [CW-1:0] credit_next;
  logic [CW-1:0] credit_left;
  logic          accept;

  // Beat handshake on the input port
  assign accept = in_tvalid && in_tready;

  // Push in flight spends one, returned credit restores one
  assign credit_next = credit_cnt - CW'(link.push) + CW'(link.credit);

  // What remains once the beat taken on this edge is pushed
  assign credit_left = credit_next - CW'(accept);

  assign link.online = tx_online;

  ////////////////////////////////////////////////////////////////////
  // Credit and handshake control
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      credit_cnt <= CW'(DEPTH);
      in_tready  <= 1'b0;
      link.push  <= 1'b0;
    end else begin
      credit_cnt <= credit_next;
      // Registered ready, only with a credit not already claimed
      in_tready  <= tx_online && (credit_left != '0);
      // One push per accepted beat, next cycle
      link.push  <= accept;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Link word register
  ////////////////////////////////////////////////////////////////////

  // Payload only, valid when push is high
  always_ff @(posedge clk_wr) begin
    if (accept) begin
      link.word <= {in_tuser, in_tkeep, in_tdata};
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////

  // Returned credit never lifts the count past the receiver depth,
  // and a wrap below zero would also land above it
  credit_in_range_a : assert property (
    @(posedge clk_wr) disable iff (reset)
    credit_cnt <= CW'(DEPTH)
  );

  // Never push without a credit held
  push_has_credit_a : assert property (
    @(posedge clk_wr) disable iff (reset)
    link.push |-> (credit_cnt != '0)
  );

endmodule

// File: st_link_rx/st_link_rx_fifo.sv
//////////////////////////////////////////////////////////////////////
// Receive FIFO
// Stores pushed link words, returns one credit per pop,
// reports level, high-water mark and overflow
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "st_link_cfg.svh"

module st_link_rx_fifo (
  input  logic                           clk_wr,
  input  logic                           reset,
  st_link_if.receiver                    link,
  output logic                           fifo_valid,
  output st_link_pkg::link_word_t        fifo_word,
  input  logic                           fifo_pop,
  output logic [`ST_LINK_STATUS_W-1:0]   rx_debug_status
);
  import st_link_pkg::*;

  localparam int DEPTH = `ST_LINK_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int LVL_W = `ST_LINK_CREDIT_W;

  link_word_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [LVL_W-1:0] level;
  logic [LVL_W-1:0] high_water;
  logic             overflow;
  logic             credit_q;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  // Circular pointer step, also fine for a depth that is not a power of 2
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full       = (level == LVL_W'(DEPTH));
  assign wr_en      = link.push && !full;
  assign rd_en      = fifo_pop && fifo_valid;
  assign fifo_valid = (level != '0);
  assign fifo_word  = mem[rd_ptr];

  ////////////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (wr_en) begin
      mem[wr_ptr] <= link.word;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      level    <= '0;
      credit_q <= 1'b0;
    end else begin
      if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
      if (rd_en) rd_ptr <= ptr_inc(rd_ptr);
      case ({wr_en, rd_en})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
      // Freed entry goes back to the sender
      credit_q <= rd_en;
    end
  end

  assign link.credit = credit_q;

  ////////////////////////////////////////////////////////////////////
  // Debug status
  ////////////////////////////////////////////////////////////////////

  // Counters restart whenever the sender drops offline
  always_ff @(posedge clk_wr) begin
    if (reset || !link.online) begin
      high_water <= '0;
      overflow   <= 1'b0;
    end else begin
      if (level > high_water) high_water <= level;
      // Sticky until offline or reset
      if (link.push && full) overflow <= 1'b1;
    end
  end

  assign rx_debug_status = {{(`ST_LINK_STATUS_W - 2*LVL_W - 1){1'b0}},
                            overflow, high_water, level};

  // Credit flow must keep the sender off a full FIFO
  no_push_full_a : assert property (
    @(posedge clk_wr) disable iff (reset)
    link.push |-> !full
  );

  // Consumer only pops what is there
  no_pop_empty_a : assert property (
    @(posedge clk_wr) disable iff (reset)
    fifo_pop |-> fifo_valid
  );

endmodule

// File: verilog/st_link_user.sv
//////////////////////////////////////////////////////////////////////
// User-side unpacker
// Pops the receive FIFO into an AXI-Stream master register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module st_link_user (
  input  logic                    clk_wr,
  input  logic                    reset,
  input  logic                    rx_online,
  input  logic                    fifo_valid,
  input  st_link_pkg::link_word_t fifo_word,
  output logic                    fifo_pop,
  output st_link_pkg::st_data_t   out_tdata,
  output st_link_pkg::st_keep_t   out_tkeep,
  output logic                    out_tuser,
  output logic                    out_tvalid,
  input  logic                    out_tready
);
  import st_link_pkg::*;

  user_state_t state;
  user_state_t state_next;
  link_word_t  out_word;
  logic        drain;

  assign out_tvalid = (state == HOLD);
  assign drain      = out_tvalid && out_tready;

  // Refill when empty or when the held beat leaves on this edge
  assign fifo_pop = rx_online && fifo_valid && ((state == EMPTY) || drain);

  ////////////////////////////////////////////////////////////////////
  // Output register FSM
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      EMPTY: if (fifo_pop) state_next = HOLD;
      HOLD:  if (drain && !fifo_pop) state_next = EMPTY;
      default: state_next = EMPTY;
    endcase
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      state <= EMPTY;
    end else begin
      state <= state_next;
    end
  end

  // Held beat, loaded on every pop
  always_ff @(posedge clk_wr) begin
    if (fifo_pop) begin
      out_word <= fifo_word;
    end
  end

  // Unpack user, keep, data
  assign {out_tuser, out_tkeep, out_tdata} = out_word;

  // Beat may not change or vanish while stalled
  out_stable_a : assert property (
    @(posedge clk_wr) disable iff (reset)
    (out_tvalid && !out_tready) |=> (out_tvalid && $stable(out_word))
  );

endmodule

// File: verilog/st_link_top.sv
//////////////////////////////////////////////////////////////////////
// Stream link top level
// Transmit packer, receive FIFO and user-side unpacker
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "st_link_cfg.svh"

module st_link_top (
  input  logic                         clk_wr,
  input  logic                         reset,

  // Link control
  input  logic                         tx_online,
  input  logic                         rx_online,

  // AXI-Stream slave side
  input  st_link_pkg::st_data_t        in_tdata,
  input  st_link_pkg::st_keep_t        in_tkeep,
  input  logic                         in_tuser,
  input  logic                         in_tvalid,
  output logic                         in_tready,

  // AXI-Stream master side
  output st_link_pkg::st_data_t        out_tdata,
  output st_link_pkg::st_keep_t        out_tkeep,
  output logic                         out_tuser,
  output logic                         out_tvalid,
  input  logic                         out_tready,

  // Receive debug
  output logic [`ST_LINK_STATUS_W-1:0] rx_debug_status
);
  import st_link_pkg::*;

  // FIFO to consumer
  logic       fifo_valid;
  logic       fifo_pop;
  link_word_t fifo_word;

  st_link_if link_if ();

  ////////////////////////////////////////////////////////////////////
  // Link blocks
  ////////////////////////////////////////////////////////////////////

  st_link_tx st_link_tx_inst (
    .clk_wr    (clk_wr),
    .reset     (reset),
    .tx_online (tx_online),
    .in_tdata  (in_tdata),
    .in_tkeep  (in_tkeep),
    .in_tuser  (in_tuser),
    .in_tvalid (in_tvalid),
    .in_tready (in_tready),
    .link      (link_if.sender)
  );

  st_link_rx_fifo st_link_rx_fifo_inst (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .link            (link_if.receiver),
    .fifo_valid      (fifo_valid),
    .fifo_word       (fifo_word),
    .fifo_pop        (fifo_pop),
    .rx_debug_status (rx_debug_status)
  );

  st_link_user st_link_user_inst (
    .clk_wr     (clk_wr),
    .reset      (reset),
    .rx_online  (rx_online),
    .fifo_valid (fifo_valid),
    .fifo_word  (fifo_word),
    .fifo_pop   (fifo_pop),
    .out_tdata  (out_tdata),
    .out_tkeep  (out_tkeep),
    .out_tuser  (out_tuser),
    .out_tvalid (out_tvalid),
    .out_tready (out_tready)
  );

endmodule

// File: test/st_link_tb.sv
//////////////////////////////////////////////////////////////////////
// Stream link testbench
// Clock, reset, scoreboard monitor, directed tests and timeout
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "st_link_cfg.svh"

module st_link_tb;
  import st_link_pkg::*;

  localparam int DEPTH          = `ST_LINK_FIFO_DEPTH;
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int BEAT_WAIT      = 200;

  logic                         clk_wr = 1'b0;
  logic                         reset;
  logic                         tx_online;
  logic                         rx_online;
  st_data_t                     in_tdata;
  st_keep_t                     in_tkeep;
  logic                         in_tuser;
  logic                         in_tvalid;
  logic                         in_tready;
  st_data_t                     out_tdata;
  st_keep_t                     out_tkeep;
  logic                         out_tuser;
  logic                         out_tvalid;
  logic                         out_tready;
  logic [`ST_LINK_STATUS_W-1:0] rx_debug_status;

  // Beats accepted at the input in arrival order
  link_word_t expq[$];
  int         errors    = 0;
  int         checks    = 0;
  int         tests     = 0;
  int         failed    = 0;
  int         rx_count  = 0;
  int         cycle_cnt = 0;

  always #2 clk_wr = ~clk_wr;

  st_link_top st_link_top_inst (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .in_tdata        (in_tdata),
    .in_tkeep        (in_tkeep),
    .in_tuser        (in_tuser),
    .in_tvalid       (in_tvalid),
    .in_tready       (in_tready),
    .out_tdata       (out_tdata),
    .out_tkeep       (out_tkeep),
    .out_tuser       (out_tuser),
    .out_tvalid      (out_tvalid),
    .out_tready      (out_tready),
    .rx_debug_status (rx_debug_status)
  );

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Scoreboard and timeout
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_wr) begin
    link_word_t exp;
    if (!reset) begin
      if (in_tvalid && in_tready) expq.push_back({in_tuser, in_tkeep, in_tdata});
      if (out_tvalid && out_tready) begin
        rx_count++;
        if (expq.size() == 0) begin
          errors++;
          $display("error: output beat appeared with no beat accepted for it");
        end else begin
          exp = expq.pop_front();
          compare_value("out_tdata", 64'(out_tdata), 64'(exp[31:0]));
          compare_value("out_tkeep", 64'(out_tkeep), 64'(exp[35:32]));
          compare_value("out_tuser", 64'(out_tuser), 64'(exp[36]));
        end
      end
    end
  end

  // Cycle limit for the whole run
  always @(posedge clk_wr) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic link_word_t rand_beat();
    return {1'($urandom), 4'($urandom), 32'($urandom)};
  endfunction

  // Leaves in_tvalid high so beats can go back to back
  task automatic send_beat(input link_word_t beat, input bit rand_ready);
    int waited;
    waited = 0;
    @(negedge clk_wr);
    {in_tuser, in_tkeep, in_tdata} = beat;
    in_tvalid = 1'b1;
    if (rand_ready) out_tready = 1'($urandom);
    @(posedge clk_wr);
    while (!in_tready && waited < BEAT_WAIT) begin
      waited++;
      @(negedge clk_wr);
      if (rand_ready) out_tready = 1'($urandom);
      @(posedge clk_wr);
    end
    if (!in_tready) begin
      errors++;
      $display("in_tready stayed low for %0d cycles with a beat offered", BEAT_WAIT);
    end
  endtask

  task automatic idle_input();
    @(negedge clk_wr);
    in_tvalid = 1'b0;
  endtask

  task automatic wait_drain(input int limit);
    int waited;
    waited = 0;
    while ((expq.size() != 0 || out_tvalid) && waited < limit) begin
      @(negedge clk_wr);
      waited++;
    end
    if (expq.size() != 0) begin
      errors++;
      $display("%0d beats still undelivered after %0d cycles", expq.size(), limit);
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    int err_before;
    int waited;
    err_before = errors;
    waited = 0;
    while (!in_tready && waited < 8) begin
      @(posedge clk_wr);
      compare_value("out_tvalid", 64'(out_tvalid), 64'(0));
      waited++;
    end
    if (!in_tready) begin
      errors++;
      $display("in_tready did not rise after reset");
    end
    compare_value("rx_debug_status", 64'(rx_debug_status), 64'(0));
    end_test("reset_state", err_before);
  endtask

  task automatic test_stream(input int beats);
    int err_before;
    int rx_start;
    err_before = errors;
    rx_start = rx_count;
    @(negedge clk_wr);
    out_tready = 1'b1;
    for (int i = 0; i < beats; i++) send_beat(rand_beat(), 1'b0);
    idle_input();
    wait_drain(100);
    compare_value("delivered", 64'(rx_count - rx_start), 64'(beats));
    end_test("stream", err_before);
  endtask

  task automatic test_full_stall();
    int         err_before;
    int         accepted;
    link_word_t beat;
    err_before = errors;
    accepted = 0;
    beat = rand_beat();
    @(negedge clk_wr);
    out_tready = 1'b0;
    // Offer beats for far longer than the link can absorb
    for (int i = 0; i < 40; i++) begin
      @(negedge clk_wr);
      {in_tuser, in_tkeep, in_tdata} = beat;
      in_tvalid = 1'b1;
      @(posedge clk_wr);
      if (in_tready) begin
        accepted++;
        beat = rand_beat();
      end
    end
    idle_input();
    compare_value("accepted", 64'(accepted), 64'(DEPTH + 1));
    // Level in [3:0], high-water mark in [7:4], overflow clear
    compare_value("rx_debug_status", 64'(rx_debug_status), 64'((DEPTH << 4) | DEPTH));
    @(negedge clk_wr);
    out_tready = 1'b1;
    wait_drain(100);
    // FIFO empty again while the high-water mark keeps its peak
    compare_value("rx_debug_status", 64'(rx_debug_status), 64'(DEPTH << 4));
    end_test("full_stall", err_before);
  endtask

  task automatic test_random_throttle(input int beats);
    int err_before;
    int gap;
    err_before = errors;
    for (int i = 0; i < beats; i++) begin
      gap = int'($urandom % 3);
      repeat (gap) begin
        @(negedge clk_wr);
        in_tvalid  = 1'b0;
        out_tready = 1'($urandom);
      end
      send_beat(rand_beat(), 1'b1);
    end
    idle_input();
    out_tready = 1'b1;
    wait_drain(200);
    compare_value("rx_debug_status[8]", 64'(rx_debug_status[8]), 64'(0));
    end_test("random_throttle", err_before);
  endtask

  task automatic test_online(input int beats);
    int err_before;
    int rx_start;
    err_before = errors;
    @(negedge clk_wr);
    tx_online = 1'b0;
    repeat (3) @(negedge clk_wr);
    in_tvalid = 1'b1;
    {in_tuser, in_tkeep, in_tdata} = rand_beat();
    repeat (10) begin
      @(posedge clk_wr);
      compare_value("in_tready", 64'(in_tready), 64'(0));
    end
    // Debug counters clear while the sender is offline
    compare_value("rx_debug_status", 64'(rx_debug_status), 64'(0));
    @(negedge clk_wr);
    in_tvalid = 1'b0;
    tx_online = 1'b1;
    rx_online = 1'b0;
    rx_start = rx_count;
    for (int i = 0; i < beats; i++) send_beat(rand_beat(), 1'b0);
    idle_input();
    // Held beats sit in the FIFO with the consumer offline
    repeat (12) begin
      @(posedge clk_wr);
      compare_value("out_tvalid", 64'(out_tvalid), 64'(0));
    end
    @(negedge clk_wr);
    rx_online = 1'b1;
    wait_drain(50);
    compare_value("delivered", 64'(rx_count - rx_start), 64'(beats));
    end_test("online", err_before);
  endtask

  initial begin
    void'($urandom(81137));
    reset      = 1'b1;
    tx_online  = 1'b1;
    rx_online  = 1'b1;
    in_tdata   = '0;
    in_tkeep   = '0;
    in_tuser   = 1'b0;
    in_tvalid  = 1'b0;
    out_tready = 1'b0;
    repeat (4) @(posedge clk_wr);
    @(negedge clk_wr);
    reset = 1'b0;

    test_reset_state();
    test_stream(50);
    test_full_stall();
    test_random_throttle(200);
    test_online(4);

    $display("tests %0d, failed %0d, checks %0d, errors %0d, beats delivered %0d",
             tests, failed, checks, errors, rx_count);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: st_link.f
+incdir+common
common/st_link_pkg.sv
common/st_link_if.sv
st_link_tx/st_link_tx.sv
st_link_rx/st_link_rx_fifo.sv
verilog/st_link_user.sv
verilog/st_link_top.sv
test/st_link_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the stream link testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=st_link_tb

verilator --binary --timing --assert -j 0 \
  -f st_link.f --top-module "$TOP" -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see $LOG"
exit 1
